//--- source/decode_pkg.sv
`default_nettype none

package decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int FUNCT3_W   = 3;
    localparam int MASK_W     = 8;
    localparam int FIFO_DEPTH = 4;

    localparam logic [XLEN-1:0]       EBREAK_WORD = 32'h0010_0073;
    localparam logic [REG_ADDR_W-1:0] HALT_RD     = 5'd10; // a0 carries the exit code

    // rv32i major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    localparam logic [6:0] F7_ALT = 7'b0100000; // sub / sra

    typedef enum logic [3:0] {
        kind_op,
        kind_op_imm,
        kind_load,
        kind_store,
        kind_branch,
        kind_jal,
        kind_jalr,
        kind_lui,
        kind_auipc,
        kind_ebreak,
        kind_illegal
    } inst_kind_e;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_sra = 3'd2,
        alu_and = 3'd3,
        alu_or  = 3'd4,
        alu_xor = 3'd5,
        alu_sll = 3'd6,
        alu_srl = 3'd7
    } alu_op_e;

    typedef enum logic [2:0] {
        rd_alu  = 3'd0,
        rd_mem  = 3'd1,
        rd_snpc = 3'd2,
        rd_cmp  = 3'd3,
        rd_none = 3'd4
    } rd_src_e;

    typedef enum logic [1:0] {
        cmp_eq  = 2'd0,
        cmp_ne  = 2'd1,
        cmp_lt  = 2'd2,
        cmp_ltu = 2'd3
    } cmp_type_e;

endpackage

`default_nettype wire

//--- source/inst_wb_slave.sv
`timescale 1ns/1ps
`default_nettype none

module inst_wb_slave (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_cyc,
    input  logic                      in_stb,
    input  logic                      in_we,
    input  logic [decode_pkg::XLEN-1:0] in_dat,
    input  logic                      full,
    output logic                      in_ack,
    output logic                      in_err,
    output logic                      push,
    output logic [decode_pkg::XLEN-1:0] push_data
);
    import decode_pkg::*;

    logic req; // new request, not yet answered

    // no second answer while the previous pulse is still visible to the master
    assign req = in_cyc && in_stb && !in_ack && !in_err;

    assign push      = req && in_we && !full; // wait states while full
    assign push_data = in_dat;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_ack <= 1'b0;
            in_err <= 1'b0;
        end else begin
            in_ack <= push;
            in_err <= req && !in_we; // reads are not supported
        end
    end

endmodule

`default_nettype wire

//--- source/inst_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module inst_fifo #(
    parameter int DEPTH = decode_pkg::FIFO_DEPTH
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  logic [decode_pkg::XLEN-1:0] push_data,
    input  logic                        pop,
    output logic [decode_pkg::XLEN-1:0] head_data,
    output logic                        full,
    output logic                        empty
);
    import decode_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [XLEN-1:0]  mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    assign full      = (count == CNT_W'(DEPTH));
    assign empty     = (count == '0);
    assign head_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  logic [decode_pkg::XLEN-1:0]       inst,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs1,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs2,
    output logic [decode_pkg::REG_ADDR_W-1:0] rd,
    output logic [decode_pkg::FUNCT3_W-1:0]   funct3,
    output logic [decode_pkg::XLEN-1:0]       imm,
    output decode_pkg::alu_op_e               alu_op,
    output logic                              alu_src1,
    output logic                              alu_src2,
    output decode_pkg::rd_src_e               rd_src,
    output logic                              jump,
    output logic                              branch,
    output decode_pkg::cmp_type_e             cmp_type,
    output logic                              mem_en,
    output logic                              mem_wen,
    output logic [decode_pkg::MASK_W-1:0]     mem_wmask,
    output logic                              stop
);
    import decode_pkg::*;

    logic [6:0]          opcode;
    logic [6:0]          funct7;
    logic [FUNCT3_W-1:0] f3;
    logic                f7_zero;
    logic                f7_alt;
    logic                is_slt;
    inst_kind_e          kind;
    logic [XLEN-1:0]     imm_i;
    logic [XLEN-1:0]     imm_s;
    logic [XLEN-1:0]     imm_b;
    logic [XLEN-1:0]     imm_u;
    logic [XLEN-1:0]     imm_j;

    assign opcode  = inst[6:0];
    assign f3      = inst[14:12];
    assign funct7  = inst[31:25];
    assign f7_zero = (funct7 == 7'b0);
    assign f7_alt  = (funct7 == F7_ALT);

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // classify, anything not matched below stops
    always_comb begin
        kind = kind_illegal;
        if (inst == EBREAK_WORD) begin
            kind = kind_ebreak;
        end else begin
            case (opcode)
                OPC_OP: begin
                    if (f7_zero || (f7_alt && (f3 == 3'b000 || f3 == 3'b101))) begin
                        kind = kind_op;
                    end
                end
                OPC_OP_IMM: begin
                    if (f3 == 3'b001) begin
                        if (f7_zero) kind = kind_op_imm; // slli
                    end else if (f3 == 3'b101) begin
                        if (f7_zero || f7_alt) kind = kind_op_imm; // srli / srai
                    end else begin
                        kind = kind_op_imm;
                    end
                end
                OPC_LOAD: begin
                    if (f3 != 3'b011 && f3[2:1] != 2'b11) kind = kind_load;
                end
                OPC_STORE: begin
                    if (!f3[2] && f3 != 3'b011) kind = kind_store;
                end
                OPC_BRANCH: begin
                    if (f3[2:1] != 2'b01) kind = kind_branch;
                end
                OPC_JAL: kind = kind_jal;
                OPC_JALR: begin
                    if (f3 == 3'b000) kind = kind_jalr;
                end
                OPC_LUI:   kind = kind_lui;
                OPC_AUIPC: kind = kind_auipc;
                default:   kind = kind_illegal;
            endcase
        end
    end

    always_comb begin
        case (kind)
            kind_op_imm, kind_load, kind_jalr: imm = imm_i;
            kind_store:                        imm = imm_s;
            kind_branch:                       imm = imm_b;
            kind_lui, kind_auipc:              imm = imm_u;
            kind_jal:                          imm = imm_j;
            default:                           imm = '0;
        endcase
    end

    // slt family goes through the subtractor, result taken from the compare
    assign is_slt = (kind == kind_op || kind == kind_op_imm) && (f3[2:1] == 2'b01);

    always_comb begin
        alu_op = alu_add;
        if (kind == kind_op || kind == kind_op_imm) begin
            case (f3)
                3'b000:         alu_op = (kind == kind_op && f7_alt) ? alu_sub : alu_add;
                3'b001:         alu_op = alu_sll;
                3'b010, 3'b011: alu_op = alu_sub;
                3'b100:         alu_op = alu_xor;
                3'b101:         alu_op = f7_alt ? alu_sra : alu_srl;
                3'b110:         alu_op = alu_or;
                default:        alu_op = alu_and;
            endcase
        end
    end

    always_comb begin
        case (kind)
            kind_load:                               rd_src = rd_mem;
            kind_jal, kind_jalr:                     rd_src = rd_snpc;
            kind_store, kind_branch:                 rd_src = rd_none;
            kind_ebreak, kind_illegal:               rd_src = rd_none;
            default:                                 rd_src = is_slt ? rd_cmp : rd_alu;
        endcase
    end

    always_comb begin
        mem_wmask = '0;
        if (kind == kind_store) begin
            case (f3)
                3'b000:  mem_wmask = 8'h01; // sb
                3'b001:  mem_wmask = 8'h03; // sh
                default: mem_wmask = 8'h0f; // sw
            endcase
        end
    end

    assign cmp_type = !is_slt ? cmp_eq : (f3[0] ? cmp_ltu : cmp_lt);
    assign alu_src1 = (kind inside {kind_auipc, kind_jal, kind_branch}); // pc
    assign alu_src2 = (kind != kind_op); // imm

    assign jump    = (kind == kind_jal) || (kind == kind_jalr);
    assign branch  = (kind == kind_branch);
    assign mem_en  = (kind == kind_load) || (kind == kind_store);
    assign mem_wen = (kind == kind_store);
    assign stop    = (kind == kind_ebreak) || (kind == kind_illegal);

    assign rs1    = (kind == kind_lui || stop) ? '0 : inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = stop ? HALT_RD : inst[11:7];
    assign funct3 = f3;

endmodule

`default_nettype wire

//--- source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [decode_pkg::XLEN-1:0]       head_data,
    input  logic                              empty,
    input  logic                              out_ack,
    output logic                              pop,
    output logic                              out_cyc,
    output logic                              out_stb,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs1,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs2,
    output logic [decode_pkg::REG_ADDR_W-1:0] rd,
    output logic [decode_pkg::FUNCT3_W-1:0]   funct3,
    output logic [decode_pkg::XLEN-1:0]       imm,
    output decode_pkg::alu_op_e               alu_op,
    output logic                              alu_src1,
    output logic                              alu_src2,
    output decode_pkg::rd_src_e               rd_src,
    output logic                              jump,
    output logic                              branch,
    output decode_pkg::cmp_type_e             cmp_type,
    output logic                              mem_en,
    output logic                              mem_wen,
    output logic [decode_pkg::MASK_W-1:0]     mem_wmask,
    output logic                              stop
);
    import decode_pkg::*;

    logic [REG_ADDR_W-1:0] dec_rs1;
    logic [REG_ADDR_W-1:0] dec_rs2;
    logic [REG_ADDR_W-1:0] dec_rd;
    logic [FUNCT3_W-1:0]   dec_funct3;
    logic [XLEN-1:0]       dec_imm;
    alu_op_e               dec_alu_op;
    logic                  dec_alu_src1;
    logic                  dec_alu_src2;
    rd_src_e               dec_rd_src;
    logic                  dec_jump;
    logic                  dec_branch;
    cmp_type_e             dec_cmp_type;
    logic                  dec_mem_en;
    logic                  dec_mem_wen;
    logic [MASK_W-1:0]     dec_mem_wmask;
    logic                  dec_stop;

    inst_decoder u_dec (
        .inst      (head_data),
        .rs1       (dec_rs1),
        .rs2       (dec_rs2),
        .rd        (dec_rd),
        .funct3    (dec_funct3),
        .imm       (dec_imm),
        .alu_op    (dec_alu_op),
        .alu_src1  (dec_alu_src1),
        .alu_src2  (dec_alu_src2),
        .rd_src    (dec_rd_src),
        .jump      (dec_jump),
        .branch    (dec_branch),
        .cmp_type  (dec_cmp_type),
        .mem_en    (dec_mem_en),
        .mem_wen   (dec_mem_wen),
        .mem_wmask (dec_mem_wmask),
        .stop      (dec_stop)
    );

    // reload when the output slot is free or being acked this edge
    assign pop     = !empty && (!out_stb || out_ack);
    assign out_cyc = out_stb; // single-beat cycles

    always_ff @(posedge clk) begin
        if (rst) begin
            out_stb <= 1'b0;
        end else if (pop) begin
            out_stb <= 1'b1;
        end else if (out_ack) begin
            out_stb <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            rs1       <= dec_rs1;
            rs2       <= dec_rs2;
            rd        <= dec_rd;
            funct3    <= dec_funct3;
            imm       <= dec_imm;
            alu_op    <= dec_alu_op;
            alu_src1  <= dec_alu_src1;
            alu_src2  <= dec_alu_src2;
            rd_src    <= dec_rd_src;
            jump      <= dec_jump;
            branch    <= dec_branch;
            cmp_type  <= dec_cmp_type;
            mem_en    <= dec_mem_en;
            mem_wen   <= dec_mem_wen;
            mem_wmask <= dec_mem_wmask;
            stop      <= dec_stop;
        end
    end

endmodule

`default_nettype wire

//--- source/decode_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              in_cyc,
    input  logic                              in_stb,
    input  logic                              in_we,
    input  logic [decode_pkg::XLEN-1:0]       in_dat,
    input  logic                              out_ack,
    output logic                              in_ack,
    output logic                              in_err,
    output logic                              out_cyc,
    output logic                              out_stb,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs1,
    output logic [decode_pkg::REG_ADDR_W-1:0] rs2,
    output logic [decode_pkg::REG_ADDR_W-1:0] rd,
    output logic [decode_pkg::FUNCT3_W-1:0]   funct3,
    output logic [decode_pkg::XLEN-1:0]       imm,
    output decode_pkg::alu_op_e               alu_op,
    output logic                              alu_src1,
    output logic                              alu_src2,
    output decode_pkg::rd_src_e               rd_src,
    output logic                              jump,
    output logic                              branch,
    output decode_pkg::cmp_type_e             cmp_type,
    output logic                              mem_en,
    output logic                              mem_wen,
    output logic [decode_pkg::MASK_W-1:0]     mem_wmask,
    output logic                              stop
);
    import decode_pkg::*;

    logic            push;
    logic [XLEN-1:0] push_data;
    logic            full;
    logic            pop;
    logic [XLEN-1:0] head_data;
    logic            empty;

    inst_wb_slave u_slave (
        .clk       (clk),
        .rst       (rst),
        .in_cyc    (in_cyc),
        .in_stb    (in_stb),
        .in_we     (in_we),
        .in_dat    (in_dat),
        .full      (full),
        .in_ack    (in_ack),
        .in_err    (in_err),
        .push      (push),
        .push_data (push_data)
    );

    inst_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head_data (head_data),
        .full      (full),
        .empty     (empty)
    );

    decode_stage u_stage (
        .clk       (clk),
        .rst       (rst),
        .head_data (head_data),
        .empty     (empty),
        .out_ack   (out_ack),
        .pop       (pop),
        .out_cyc   (out_cyc),
        .out_stb   (out_stb),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .funct3    (funct3),
        .imm       (imm),
        .alu_op    (alu_op),
        .alu_src1  (alu_src1),
        .alu_src2  (alu_src2),
        .rd_src    (rd_src),
        .jump      (jump),
        .branch    (branch),
        .cmp_type  (cmp_type),
        .mem_en    (mem_en),
        .mem_wen   (mem_wen),
        .mem_wmask (mem_wmask),
        .stop      (stop)
    );

endmodule

`default_nettype wire

//--- sim/tb_decode_ref.svh
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

typedef struct packed {
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [2:0]  funct3;
    logic [31:0] imm;
    alu_op_e     alu_op;
    logic        alu_src1;
    logic        alu_src2;
    rd_src_e     rd_src;
    logic        jump;
    logic        branch;
    cmp_type_e   cmp_type;
    logic        mem_en;
    logic        mem_wen;
    logic [7:0]  mem_wmask;
    logic        stop;
} dec_fields_t;

function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// expected control fields of one word, straight from the rv32i encoding rules
function automatic dec_fields_t decode_ref(input logic [31:0] w);
    dec_fields_t d;
    inst_kind_e  k;
    logic [6:0]  op;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        alt;
    logic        slt_fam;
    op  = w[6:0];
    f3  = w[14:12];
    f7  = w[31:25];
    alt = (f7 == 7'h20);
    d   = '0;
    k   = kind_illegal;
    if (w == EBREAK_WORD) begin
        k = kind_ebreak;
    end else begin
        case (op)
            7'h33: if (f7 == 7'h00 || (alt && f3 inside {3'd0, 3'd5})) k = kind_op;
            7'h13: begin
                if (!(f3 inside {3'd1, 3'd5}) || f7 == 7'h00 || (alt && f3 == 3'd5)) begin
                    k = kind_op_imm;
                end
            end
            7'h03: if (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) k = kind_load;
            7'h23: if (f3 inside {3'd0, 3'd1, 3'd2}) k = kind_store;
            7'h63: if (!(f3 inside {3'd2, 3'd3})) k = kind_branch;
            7'h6f: k = kind_jal;
            7'h67: if (f3 == 3'd0) k = kind_jalr;
            7'h37: k = kind_lui;
            7'h17: k = kind_auipc;
            default: k = kind_illegal;
        endcase
    end

    case (k)
        kind_op_imm, kind_load, kind_jalr: d.imm = 32'($signed(w[31:20]));
        kind_store:  d.imm = 32'($signed({w[31:25], w[11:7]}));
        kind_branch: d.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
        kind_lui, kind_auipc: d.imm = {w[31:12], 12'h000};
        kind_jal:    d.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
        default:     d.imm = 32'h0;
    endcase

    slt_fam  = (k inside {kind_op, kind_op_imm}) && (f3 inside {3'd2, 3'd3});
    d.alu_op = alu_add;
    if (k inside {kind_op, kind_op_imm}) begin
        case (f3)
            3'd0: d.alu_op = (k == kind_op && alt) ? alu_sub : alu_add;
            3'd1: d.alu_op = alu_sll;
            3'd2, 3'd3: d.alu_op = alu_sub; // compare via subtract
            3'd4: d.alu_op = alu_xor;
            3'd5: d.alu_op = alt ? alu_sra : alu_srl;
            3'd6: d.alu_op = alu_or;
            default: d.alu_op = alu_and;
        endcase
    end

    d.stop     = (k == kind_ebreak) || (k == kind_illegal);
    d.alu_src1 = k inside {kind_auipc, kind_jal, kind_branch};
    d.alu_src2 = (k != kind_op);
    if (d.stop || k == kind_store || k == kind_branch) d.rd_src = rd_none;
    else if (k == kind_load) d.rd_src = rd_mem;
    else if (k == kind_jal || k == kind_jalr) d.rd_src = rd_snpc;
    else if (slt_fam) d.rd_src = rd_cmp;
    else d.rd_src = rd_alu;
    d.cmp_type = slt_fam ? ((f3 == 3'd3) ? cmp_ltu : cmp_lt) : cmp_eq;

    d.mem_en  = (k == kind_load) || (k == kind_store);
    d.mem_wen = (k == kind_store);
    if (k == kind_store) begin
        d.mem_wmask = (f3 == 3'd0) ? 8'h01 : ((f3 == 3'd1) ? 8'h03 : 8'h0f);
    end
    d.jump   = (k == kind_jal) || (k == kind_jalr);
    d.branch = (k == kind_branch);
    d.rs1    = (k == kind_lui || d.stop) ? 5'd0 : w[19:15];
    d.rs2    = w[24:20];
    d.rd     = d.stop ? HALT_RD : w[11:7];
    d.funct3 = f3;
    return d;
endfunction

`endif

//--- sim/tb_decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_unit;
    import decode_pkg::*;

    `include "tb_decode_ref.svh"

    localparam int CLK_PERIOD   = 100;
    localparam logic [31:0] SEED = 32'hffe6_13df;
    localparam int N_DIRECTED   = 41;
    localparam int N_RANDOM     = 200;
    localparam int N_STALL      = 6;
    localparam int STALL_CYCLES = 20;
    localparam int N_WORDS      = N_DIRECTED + N_RANDOM + N_STALL + 2;
    localparam int DRAIN_LIMIT  = 200;
    localparam int WATCHDOG_NS  = (N_WORDS + 20) * 8 * CLK_PERIOD;

    localparam logic [6:0] OPCODES [9] = '{7'h33, 7'h13, 7'h03, 7'h23, 7'h63,
                                           7'h6f, 7'h67, 7'h37, 7'h17};

    // every kept instruction, then ebreak, ecall, csrrw and an R-type with funct7 01
    localparam logic [31:0] DIRECTED [N_DIRECTED] = '{
        32'h123452b7, 32'hfffff317, 32'h008000ef, 32'h004100e7,
        32'h00310463, 32'hfe311ee3, 32'h00314463, 32'h00315463,
        32'h00316463, 32'h00317463, 32'h01010083, 32'h01011083,
        32'h01012083, 32'h01014083, 32'h01015083, 32'hfe310e23,
        32'hfe311e23, 32'hfe312e23, 32'hffb10093, 32'hffb12093,
        32'hffb13093, 32'hffb14093, 32'hffb16093, 32'hffb17093,
        32'h00311093, 32'h00315093, 32'h40315093, 32'h003100b3,
        32'h403100b3, 32'h003110b3, 32'h003120b3, 32'h003130b3,
        32'h003140b3, 32'h003150b3, 32'h403150b3, 32'h003160b3,
        32'h003170b3, 32'h00100073, 32'h00000073, 32'h305110f3,
        32'h023100b3
    };

    logic        clk;
    logic        rst;
    logic        in_cyc;
    logic        in_stb;
    logic        in_we;
    logic [31:0] in_dat;
    logic        out_ack;
    logic        in_ack;
    logic        in_err;
    logic        out_cyc;
    logic        out_stb;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [2:0]  funct3;
    logic [31:0] imm;
    alu_op_e     alu_op;
    logic        alu_src1;
    logic        alu_src2;
    rd_src_e     rd_src;
    logic        jump;
    logic        branch;
    cmp_type_e   cmp_type;
    logic        mem_en;
    logic        mem_wen;
    logic [7:0]  mem_wmask;
    logic        stop;

    dec_fields_t actual;
    dec_fields_t held_val;
    logic        held;
    logic        hold_ack;
    logic [31:0] exp_words [N_WORDS];
    logic [31:0] word_state;
    logic [31:0] ack_state;
    int          ack_wait;
    int          n_acked;
    int          n_out;
    int          errors;
    int          order_errs;
    int          mismatches;

    decode_unit_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_cyc    (in_cyc),
        .in_stb    (in_stb),
        .in_we     (in_we),
        .in_dat    (in_dat),
        .out_ack   (out_ack),
        .in_ack    (in_ack),
        .in_err    (in_err),
        .out_cyc   (out_cyc),
        .out_stb   (out_stb),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .funct3    (funct3),
        .imm       (imm),
        .alu_op    (alu_op),
        .alu_src1  (alu_src1),
        .alu_src2  (alu_src2),
        .rd_src    (rd_src),
        .jump      (jump),
        .branch    (branch),
        .cmp_type  (cmp_type),
        .mem_en    (mem_en),
        .mem_wen   (mem_wen),
        .mem_wmask (mem_wmask),
        .stop      (stop)
    );

    assign actual = {rs1, rs2, rd, funct3, imm, alu_op, alu_src1, alu_src2, rd_src,
                     jump, branch, cmp_type, mem_en, mem_wen, mem_wmask, stop};

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            mismatches++;
            $display("[FAIL] t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
        end
    endtask

    task automatic compare_fields(input string tag, input dec_fields_t e,
                                  input dec_fields_t a);
        check_field({tag, ".rs1"}, 32'(e.rs1), 32'(a.rs1));
        check_field({tag, ".rs2"}, 32'(e.rs2), 32'(a.rs2));
        check_field({tag, ".rd"}, 32'(e.rd), 32'(a.rd));
        check_field({tag, ".funct3"}, 32'(e.funct3), 32'(a.funct3));
        check_field({tag, ".imm"}, e.imm, a.imm);
        check_field({tag, ".alu_op"}, 32'(e.alu_op), 32'(a.alu_op));
        check_field({tag, ".alu_src1"}, 32'(e.alu_src1), 32'(a.alu_src1));
        check_field({tag, ".alu_src2"}, 32'(e.alu_src2), 32'(a.alu_src2));
        check_field({tag, ".rd_src"}, 32'(e.rd_src), 32'(a.rd_src));
        check_field({tag, ".jump"}, 32'(e.jump), 32'(a.jump));
        check_field({tag, ".branch"}, 32'(e.branch), 32'(a.branch));
        check_field({tag, ".cmp_type"}, 32'(e.cmp_type), 32'(a.cmp_type));
        check_field({tag, ".mem_en"}, 32'(e.mem_en), 32'(a.mem_en));
        check_field({tag, ".mem_wen"}, 32'(e.mem_wen), 32'(a.mem_wen));
        check_field({tag, ".mem_wmask"}, 32'(e.mem_wmask), 32'(a.mem_wmask));
        check_field({tag, ".stop"}, 32'(e.stop), 32'(a.stop));
    endtask

    // mostly kept opcodes with the odd random one or ebreak
    function automatic logic [31:0] random_word(inout logic [31:0] state);
        logic [31:0] sel;
        logic [31:0] w;
        state = lcg_next(state);
        sel   = state;
        state = lcg_next(state);
        w     = state;
        if (sel[31:28] == 4'h0) w[6:0] = sel[6:0];
        else w[6:0] = OPCODES[int'(sel[27:24]) % 9];
        if (sel[20] && (w[6:0] == 7'h33 || w[6:0] == 7'h13)) begin
            w[31:25] = sel[21] ? 7'h20 : 7'h00; // legal funct7 more often
        end
        if (sel[15:10] == 6'd0) w = EBREAK_WORD;
        return w;
    endfunction

    // starts and ends 1 ns after a rising edge
    task automatic bus_cycle(input logic we, input logic [31:0] data,
                             output logic got_ack, output logic got_err);
        in_cyc  = 1'b1;
        in_stb  = 1'b1;
        in_we   = we;
        in_dat  = data;
        got_ack = 1'b0;
        got_err = 1'b0;
        while (!got_ack && !got_err) begin
            @(posedge clk);
            #1;
            got_ack = in_ack;
            got_err = in_err;
        end
        in_cyc = 1'b0;
        in_stb = 1'b0;
        in_we  = 1'b0;
        if (got_ack && n_acked < N_WORDS) begin
            exp_words[n_acked] = data;
            n_acked++;
        end
    endtask

    task automatic write_word(input logic [31:0] data);
        logic a;
        logic e;
        bus_cycle(1'b1, data, a, e);
        if (e) begin
            errors++;
            $display("ERROR: t=%0t write of %h answered with in_err", $time, data);
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((n_out != n_acked || out_stb) && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (n_out != n_acked || out_stb) begin
            errors++;
            $display("ERROR: t=%0t pipeline did not drain, %0d written %0d out",
                     $time, n_acked, n_out);
        end
    endtask

    // downstream slave waits 0 to 3 cycles before each ack
    initial begin : ack_driver
        out_ack   = 1'b0;
        ack_state = SEED;
        ack_wait  = 0;
        forever begin
            @(posedge clk);
            #1;
            if (out_ack) begin
                ack_state = lcg_next(ack_state);
                ack_wait  = int'(ack_state[17:16]);
            end
            if (out_stb && !hold_ack && ack_wait == 0) begin
                out_ack = 1'b1;
            end else begin
                out_ack = 1'b0;
                if (out_stb && !hold_ack && ack_wait > 0) ack_wait--;
            end
        end
    end

    // scoreboard samples at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (out_cyc !== out_stb) begin
                mismatches++;
                $display("[FAIL] t=%0t out_cyc expected=%0h actual=%0h", $time, out_stb, out_cyc);
            end
            if (held && out_stb) compare_fields("held", held_val, actual);
            if (out_stb && out_ack) begin
                if (n_out >= n_acked) begin
                    order_errs++;
                    $display("ERROR: t=%0t output word with no accepted write", $time);
                end else begin
                    compare_fields("out", decode_ref(exp_words[n_out]), actual);
                end
                n_out++;
            end
            held     = out_stb && !out_ack;
            held_val = actual;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("ERROR: timeout after %0d ns, %0d written %0d out", WATCHDOG_NS, n_acked, n_out);
        $display("TB FAILED");
        $finish;
    end

    initial begin : main
        int   i;
        int   base;
        logic got_ack;
        logic got_err;
        clk        = 1'b0;
        rst        = 1'b1;
        in_cyc     = 1'b0;
        in_stb     = 1'b0;
        in_we      = 1'b0;
        in_dat     = 32'h0;
        hold_ack   = 1'b0;
        held       = 1'b0;
        word_state = SEED;
        n_acked    = 0;
        n_out      = 0;
        errors     = 0;
        order_errs = 0;
        mismatches = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        @(negedge clk);
        if (in_ack !== 1'b0 || in_err !== 1'b0 || out_cyc !== 1'b0 || out_stb !== 1'b0) begin
            errors++;
            $display("ERROR: t=%0t bus outputs not idle after reset", $time);
        end
        @(posedge clk);
        #1;

        for (i = 0; i < N_DIRECTED; i++) write_word(DIRECTED[i]);
        wait_drain();

        for (i = 0; i < N_RANDOM; i++) write_word(random_word(word_state));
        wait_drain();

        // FIFO and output register fill while the output stalls
        base     = n_acked;
        hold_ack = 1'b1;
        fork
            begin
                for (i = 0; i < N_STALL; i++) write_word(random_word(word_state));
            end
            begin
                repeat (STALL_CYCLES) @(posedge clk);
                #1;
                if (n_acked - base != FIFO_DEPTH + 1) begin
                    errors++;
                    $display("ERROR: t=%0t %0d writes accepted under stall, expected %0d",
                             $time, n_acked - base, FIFO_DEPTH + 1);
                end
                hold_ack = 1'b0;
            end
        join
        wait_drain();

        // read cycle is refused and leaves no word behind
        bus_cycle(1'b0, 32'h0000_0013, got_ack, got_err);
        if (got_ack) begin
            errors++;
            $display("ERROR: t=%0t read cycle was acknowledged", $time);
        end
        if (!got_err) begin
            errors++;
            $display("ERROR: t=%0t read cycle got no in_err", $time);
        end
        write_word(32'h00a00513);
        wait_drain();

        if (n_out != n_acked) begin
            errors++;
            $display("ERROR: %0d words accepted but %0d words delivered", n_acked, n_out);
        end
        $display("errors=%0d mismatches=%0d words_in=%0d words_out=%0d",
                 errors + order_errs, mismatches, n_acked, n_out);
        if (errors + order_errs + mismatches == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+sim
source/decode_pkg.sv
source/inst_wb_slave.sv
source/inst_fifo.sv
source/inst_decoder.sv
source/decode_stage.sv
source/decode_unit_top.sv
sim/tb_decode_unit.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it, and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_decode_unit -f project.f \
    && ./obj_dir/Vtb_decode_unit > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TB PASSED" sim.log && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
